// File: hw/lcd_cmd_pkg.sv
//####################################################################
// ST7735 command opcodes, the power-up init table
// and the panel reset timing and window origin constants
//####################################################################
package lcd_cmd_pkg;

   typedef enum logic [7:0] {
      SWRESET = 8'h01,
      SLPOUT  = 8'h11,
      INVCTR  = 8'hB4,
      PWCTR1  = 8'hC0,
      PWCTR4  = 8'hC3,
      PWCTR5  = 8'hC4,
      VMCTR1  = 8'hC5,
      INVON   = 8'h21,
      MADCTL  = 8'h36,
      COLMOD  = 8'h3A,
      CASET   = 8'h2A,
      RASET   = 8'h2B,
      NORON   = 8'h13,
      DISPON  = 8'h29,
      RAMWR   = 8'h2C
   } lcd_opcode_e;

   typedef enum logic [1:0] {INIT_CMD, INIT_DATA, INIT_DELAY} init_kind_e;

   localparam int INIT_LEN = 27;

   // one entry per byte or delay, delays are in ms
   localparam init_kind_e INIT_KIND [INIT_LEN] = '{
      INIT_CMD, INIT_DELAY, INIT_CMD, INIT_DELAY,                // resets, sleep out
      INIT_CMD, INIT_DATA,                                       // inversion ctrl
      INIT_CMD, INIT_DATA, INIT_DATA, INIT_DATA,                 // power ctrl 1
      INIT_CMD, INIT_DATA, INIT_DATA, INIT_CMD, INIT_DATA, INIT_DATA,
      INIT_CMD, INIT_DATA, INIT_CMD,                             // vcom, inversion on
      INIT_CMD, INIT_DATA, INIT_CMD, INIT_DATA,                  // madctl, colmod
      INIT_CMD, INIT_DELAY, INIT_CMD, INIT_DELAY};

   localparam logic [7:0] INIT_VALUE [INIT_LEN] = '{
      SWRESET, 8'd150, SLPOUT, 8'd250,
      INVCTR, 8'h07,
      PWCTR1, 8'hA2, 8'h02, 8'h84,
      PWCTR4, 8'h8A, 8'h2A, PWCTR5, 8'h8A, 8'hEE,
      VMCTR1, 8'h0E, INVON,
      MADCTL, 8'hC8, COLMOD, 8'h05,                              // 16 bit colour
      NORON, 8'd10, DISPON, 8'd100};

   localparam int RESET_LOW_MS  = 10;   // panel reset pulse
   localparam int RESET_WAIT_MS = 120;  // settle before first command

   // window origin in panel RAM
   localparam logic [7:0] COL_OFFSET = 8'h00;
   localparam logic [7:0] ROW_OFFSET = 8'h00;

endpackage

// File: hw/lcd_link_pkg.sv
//####################################################################
// sequencer state encoding and SPI byte kind
//####################################################################
package lcd_link_pkg;

   typedef enum logic [2:0] {
      ST_WAIT_READY,  // panel reset still running
      ST_TABLE,       // next init table entry
      ST_DELAY,       // ms wait after a command
      ST_WINDOW,      // CASET / RASET and their bytes
      ST_RAMWR,
      ST_FETCH,       // pixel request out, waiting for colour
      ST_PIX_HI,
      ST_PIX_LO
   } seq_state_e;

   // level put on the dc pin for the byte
   typedef enum logic {
      KIND_CMD  = 1'b0,
      KIND_DATA = 1'b1
   } byte_kind_e;

endpackage

// File: hw/spi_byte_tx.sv
//####################################################################
// write-only SPI byte serializer, MSB first
// sclk idles high, data moves on the falling edge
//####################################################################
`timescale 1ns/1ps

module spi_byte_tx #(
   parameter int CLK_HALF_CYCLES = 2
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     tx_start,
   input  logic [7:0]               tx_byte,
   input  lcd_link_pkg::byte_kind_e tx_kind,
   output logic                     tx_busy,
   output logic                     sclk,
   output logic                     mosi,
   output logic                     dc,
   output logic                     cs
);

   logic [$clog2(CLK_HALF_CYCLES+1)-1:0] div_cnt;
   logic [3:0] bit_cnt;  // 8 means guard half with cs high
   logic [7:0] shift_q;
   logic       dc_q;
   logic       half_end;
   logic       load;
   logic       step;

   assign half_end = (div_cnt == CLK_HALF_CYCLES - 1);
   assign load     = tx_start && !tx_busy;
   // falling edge inside the byte brings out the next bit
   assign step     = tx_busy && half_end && sclk && (bit_cnt < 4'd7);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx_busy <= 1'b0;
         sclk    <= 1'b1;
         cs      <= 1'b1;
         div_cnt <= '0;
         bit_cnt <= '0;
      end else if (!tx_busy) begin
         div_cnt <= '0;
         if (tx_start) begin
            tx_busy <= 1'b1;
            cs      <= 1'b0;
            sclk    <= 1'b0;  // first fall presents bit 7
            bit_cnt <= '0;
         end
      end else if (!half_end) begin
         div_cnt <= div_cnt + 1'b1;
      end else begin
         div_cnt <= '0;
         if (bit_cnt == 4'd8) begin
            tx_busy <= 1'b0;
         end else if (!sclk) begin
            sclk <= 1'b1;     // panel samples here
         end else if (bit_cnt == 4'd7) begin
            cs      <= 1'b1;  // last bit done, keep sclk high
            bit_cnt <= 4'd8;
         end else begin
            sclk    <= 1'b0;
            bit_cnt <= bit_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         shift_q <= tx_byte;
         dc_q    <= (tx_kind == lcd_link_pkg::KIND_DATA);
      end else if (step) begin
         shift_q <= {shift_q[6:0], 1'b0};
      end
   end

   assign mosi = shift_q[7];
   assign dc   = dc_q;

endmodule

// File: hw/panel_reset_gen.sv
//####################################################################
// panel hardware reset: timed low pulse, settle wait, then ready
//####################################################################
`timescale 1ns/1ps

module panel_reset_gen #(
   parameter int CYCLES_PER_MS = 12000
) (
   input  logic clk,
   input  logic rst_n,
   output logic lcd_rst,
   output logic ready
);

   localparam int TOTAL_MS = lcd_cmd_pkg::RESET_LOW_MS + lcd_cmd_pkg::RESET_WAIT_MS;

   logic [$clog2(CYCLES_PER_MS+1)-1:0] cyc_cnt;
   logic [$clog2(TOTAL_MS+1)-1:0]      ms_cnt;  // whole ms since reset

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cyc_cnt <= '0;
         ms_cnt  <= '0;
         lcd_rst <= 1'b0;
         ready   <= 1'b0;
      end else if (!ready) begin
         if (cyc_cnt == CYCLES_PER_MS - 1) begin
            cyc_cnt <= '0;
            ms_cnt  <= ms_cnt + 1'b1;
            if (ms_cnt == lcd_cmd_pkg::RESET_LOW_MS - 1)
               lcd_rst <= 1'b1;   // end of pulse
            if (ms_cnt == TOTAL_MS - 1)
               ready <= 1'b1;     // stays high until next reset
         end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
         end
      end
   end

endmodule

// File: hw/lcd_sequencer.sv
//####################################################################
// ST7735 command sequencer: init table with delays,
// then per frame the address window, RAMWR and pixel bytes
//####################################################################
`timescale 1ns/1ps

module lcd_sequencer #(
   parameter int SCREEN_WIDTH  = 160,
   parameter int SCREEN_HEIGHT = 80,
   parameter int CYCLES_PER_MS = 12000
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     ready,
   input  logic                     tx_busy,
   input  logic                     pix_ready,
   input  logic [15:0]              pix_color,
   input  logic                     frame_last,
   output logic                     tx_start,
   output logic [7:0]               tx_byte,
   output lcd_link_pkg::byte_kind_e tx_kind,
   output logic                     fetch
);

   localparam logic [15:0] COL_START = 16'(lcd_cmd_pkg::COL_OFFSET);
   localparam logic [15:0] ROW_START = 16'(lcd_cmd_pkg::ROW_OFFSET);
   localparam logic [15:0] COL_END   = COL_START + 16'(SCREEN_WIDTH - 1);
   localparam logic [15:0] ROW_END   = ROW_START + 16'(SCREEN_HEIGHT - 1);

   // CASET and its four bytes, then RASET and its four bytes
   localparam logic [7:0] WIN_BYTES [10] = '{
      lcd_cmd_pkg::CASET, COL_START[15:8], COL_START[7:0], COL_END[15:8], COL_END[7:0],
      lcd_cmd_pkg::RASET, ROW_START[15:8], ROW_START[7:0], ROW_END[15:8], ROW_END[7:0]};

   lcd_link_pkg::seq_state_e state;
   logic [$clog2(lcd_cmd_pkg::INIT_LEN)-1:0] idx;
   logic [$clog2(CYCLES_PER_MS+1)-1:0]       dly_cyc;
   logic [7:0] dly_ms;       // ms still to wait
   logic [3:0] win_idx;
   logic       fetch_wait;   // request out, colour not back yet
   logic       can_send;
   logic       table_last;
   lcd_link_pkg::byte_kind_e entry_kind;
   lcd_link_pkg::byte_kind_e win_kind;

   assign can_send   = !tx_busy && !tx_start;  // busy shows one cycle after start
   assign table_last = (idx == lcd_cmd_pkg::INIT_LEN - 1);
   assign entry_kind = (lcd_cmd_pkg::INIT_KIND[idx] == lcd_cmd_pkg::INIT_CMD) ?
                       lcd_link_pkg::KIND_CMD : lcd_link_pkg::KIND_DATA;
   assign win_kind   = (win_idx == 4'd0 || win_idx == 4'd5) ?
                       lcd_link_pkg::KIND_CMD : lcd_link_pkg::KIND_DATA;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= lcd_link_pkg::ST_WAIT_READY;
         idx        <= '0;
         dly_cyc    <= '0;
         dly_ms     <= '0;
         win_idx    <= '0;
         fetch_wait <= 1'b0;
         tx_start   <= 1'b0;
         tx_byte    <= '0;
         tx_kind    <= lcd_link_pkg::KIND_CMD;
         fetch      <= 1'b0;
      end else begin
         tx_start <= 1'b0;
         fetch    <= 1'b0;
         case (state)
            lcd_link_pkg::ST_WAIT_READY: begin
               if (ready)
                  state <= lcd_link_pkg::ST_TABLE;
            end
            lcd_link_pkg::ST_TABLE: begin
               if (can_send) begin
                  if (lcd_cmd_pkg::INIT_KIND[idx] == lcd_cmd_pkg::INIT_DELAY) begin
                     dly_ms  <= lcd_cmd_pkg::INIT_VALUE[idx];
                     dly_cyc <= '0;
                     state   <= lcd_link_pkg::ST_DELAY;  // link idle, start timing
                  end else begin
                     tx_start <= 1'b1;
                     tx_byte  <= lcd_cmd_pkg::INIT_VALUE[idx];
                     tx_kind  <= entry_kind;
                     if (table_last)
                        state <= lcd_link_pkg::ST_WINDOW;
                     else
                        idx <= idx + 1'b1;
                  end
               end
            end
            lcd_link_pkg::ST_DELAY: begin
               if (dly_cyc == CYCLES_PER_MS - 1) begin
                  dly_cyc <= '0;
                  dly_ms  <= dly_ms - 1'b1;
                  if (dly_ms == 8'd1) begin
                     if (table_last) begin
                        state <= lcd_link_pkg::ST_WINDOW;
                     end else begin
                        idx   <= idx + 1'b1;
                        state <= lcd_link_pkg::ST_TABLE;
                     end
                  end
               end else begin
                  dly_cyc <= dly_cyc + 1'b1;
               end
            end
            lcd_link_pkg::ST_WINDOW: begin
               if (can_send) begin
                  tx_start <= 1'b1;
                  tx_byte  <= WIN_BYTES[win_idx];
                  tx_kind  <= win_kind;
                  if (win_idx == 4'd9) begin
                     win_idx <= '0;
                     state   <= lcd_link_pkg::ST_RAMWR;
                  end else begin
                     win_idx <= win_idx + 1'b1;
                  end
               end
            end
            lcd_link_pkg::ST_RAMWR: begin
               if (can_send) begin
                  tx_start <= 1'b1;
                  tx_byte  <= lcd_cmd_pkg::RAMWR;
                  tx_kind  <= lcd_link_pkg::KIND_CMD;
                  state    <= lcd_link_pkg::ST_FETCH;
               end
            end
            lcd_link_pkg::ST_FETCH: begin
               // ask only once the link is quiet so cs holds during the wait
               if (!fetch_wait && can_send) begin
                  fetch      <= 1'b1;
                  fetch_wait <= 1'b1;
               end else if (pix_ready) begin
                  fetch_wait <= 1'b0;
                  state      <= lcd_link_pkg::ST_PIX_HI;
               end
            end
            lcd_link_pkg::ST_PIX_HI: begin
               if (can_send) begin
                  tx_start <= 1'b1;
                  tx_byte  <= pix_color[15:8];
                  tx_kind  <= lcd_link_pkg::KIND_DATA;
                  state    <= lcd_link_pkg::ST_PIX_LO;
               end
            end
            lcd_link_pkg::ST_PIX_LO: begin
               if (can_send) begin
                  tx_start <= 1'b1;
                  tx_byte  <= pix_color[7:0];
                  tx_kind  <= lcd_link_pkg::KIND_DATA;
                  state    <= frame_last ? lcd_link_pkg::ST_WINDOW : lcd_link_pkg::ST_FETCH;
               end
            end
            default: state <= lcd_link_pkg::ST_WAIT_READY;
         endcase
      end
   end

endmodule

// File: hw/frame_scanner.sv
//####################################################################
// raster x/y counters with pixel request handshake and colour hold
//####################################################################
`timescale 1ns/1ps

module frame_scanner #(
   parameter int SCREEN_WIDTH  = 160,
   parameter int SCREEN_HEIGHT = 80
) (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             fetch,
   input  logic [15:0]                      color,
   input  logic                             color_valid,
   output logic                             pixel_req,
   output logic [$clog2(SCREEN_WIDTH)-1:0]  pixel_x,
   output logic [$clog2(SCREEN_HEIGHT)-1:0] pixel_y,
   output logic                             pix_ready,
   output logic [15:0]                      pix_color,
   output logic                             frame_last
);

   logic take;
   logic row_end;
   logic col_end;

   assign take    = pixel_req && color_valid;
   assign row_end = (pixel_x == SCREEN_WIDTH - 1);
   assign col_end = (pixel_y == SCREEN_HEIGHT - 1);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pixel_req  <= 1'b0;
         pixel_x    <= '0;
         pixel_y    <= '0;
         pix_ready  <= 1'b0;
         frame_last <= 1'b0;
      end else begin
         pix_ready <= take;
         if (fetch) begin
            pixel_req <= 1'b1;
         end else if (take) begin
            pixel_req  <= 1'b0;
            frame_last <= row_end && col_end;  // held until the next capture
            pixel_x    <= row_end ? '0 : pixel_x + 1'b1;
            if (row_end)
               pixel_y <= col_end ? '0 : pixel_y + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take)
         pix_color <= color;
   end

endmodule

// File: hw/st7735_top.sv
//####################################################################
// ST7735 driver top: reset generator, sequencer,
// SPI serializer and pixel scanner
//####################################################################
`timescale 1ns/1ps

module st7735_top #(
   parameter int CLK_HALF_CYCLES = 2,
   parameter int CYCLES_PER_MS   = 12000,
   parameter int SCREEN_WIDTH    = 160,
   parameter int SCREEN_HEIGHT   = 80
) (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic [15:0]                      color,
   input  logic                             color_valid,
   output logic                             lcd_sclk,
   output logic                             lcd_mosi,
   output logic                             lcd_dc,
   output logic                             lcd_cs,
   output logic                             lcd_rst,
   output logic                             pixel_req,
   output logic [$clog2(SCREEN_WIDTH)-1:0]  pixel_x,
   output logic [$clog2(SCREEN_HEIGHT)-1:0] pixel_y
);

   logic                     ready;
   logic                     tx_start;
   logic [7:0]               tx_byte;
   lcd_link_pkg::byte_kind_e tx_kind;
   logic                     tx_busy;
   logic                     fetch;
   logic                     pix_ready;
   logic [15:0]              pix_color;
   logic                     frame_last;

   panel_reset_gen #(.CYCLES_PER_MS(CYCLES_PER_MS)) reset_gen_i (
      .clk(clk), .rst_n(rst_n), .lcd_rst(lcd_rst), .ready(ready));

   lcd_sequencer #(
      .SCREEN_WIDTH(SCREEN_WIDTH),
      .SCREEN_HEIGHT(SCREEN_HEIGHT),
      .CYCLES_PER_MS(CYCLES_PER_MS)
   ) sequencer_i (
      .clk(clk), .rst_n(rst_n), .ready(ready), .tx_busy(tx_busy),
      .pix_ready(pix_ready), .pix_color(pix_color), .frame_last(frame_last),
      .tx_start(tx_start), .tx_byte(tx_byte), .tx_kind(tx_kind), .fetch(fetch));

   spi_byte_tx #(.CLK_HALF_CYCLES(CLK_HALF_CYCLES)) spi_tx_i (
      .clk(clk), .rst_n(rst_n), .tx_start(tx_start), .tx_byte(tx_byte),
      .tx_kind(tx_kind), .tx_busy(tx_busy), .sclk(lcd_sclk), .mosi(lcd_mosi),
      .dc(lcd_dc), .cs(lcd_cs));

   frame_scanner #(.SCREEN_WIDTH(SCREEN_WIDTH), .SCREEN_HEIGHT(SCREEN_HEIGHT)) scanner_i (
      .clk(clk), .rst_n(rst_n), .fetch(fetch), .color(color), .color_valid(color_valid),
      .pixel_req(pixel_req), .pixel_x(pixel_x), .pixel_y(pixel_y),
      .pix_ready(pix_ready), .pix_color(pix_color), .frame_last(frame_last));

endmodule

// File: tb/spi_byte_decoder.sv
//####################################################################
// testbench SPI monitor, rebuilds bytes and their dc level
// plus start and end times from the panel pins
//####################################################################
`timescale 1ns/1ps

module spi_byte_decoder (
   input  logic        sclk,
   input  logic        mosi,
   input  logic        dc,
   input  logic        cs,
   output logic [7:0]  rx_byte,
   output logic        rx_dc,
   output logic [63:0] rx_start,  // cs falling edge in ns
   output logic [63:0] rx_end,    // last rising sclk in ns
   output int          rx_count
);

   logic [7:0]  shift_q;
   logic [63:0] start_q;
   int          bits;

   initial begin
      rx_byte  = '0;
      rx_dc    = 1'b0;
      rx_start = '0;
      rx_end   = '0;
      rx_count = 0;
      bits     = 0;
   end

   always @(negedge cs) begin
      bits    = 0;
      start_q = $time;
   end

   always @(posedge sclk) begin
      if (cs === 1'b0) begin
         shift_q = {shift_q[6:0], mosi};  // MSB arrives first
         bits    = bits + 1;
         if (bits == 8) begin
            rx_byte  <= shift_q;
            rx_dc    <= dc;      // dc taken with the last bit
            rx_start <= start_q;
            rx_end   <= $time;
            rx_count <= rx_count + 1;
            bits      = 0;
         end
      end
   end

endmodule

// File: tb/tb_st7735.sv
//####################################################################
// testbench for the ST7735 driver: clock, reset, pixel source
// model, byte stream and handshake checks, run timeout
//####################################################################
`timescale 1ns/1ps

module tb_st7735;

   localparam int CLK_PERIOD      = 20;
   localparam int CLK_HALF_CYCLES = 2;
   localparam int CYCLES_PER_MS   = 4;
   localparam int W               = 4;
   localparam int H               = 3;
   localparam int RST_LOW_CYCLES  = lcd_cmd_pkg::RESET_LOW_MS * CYCLES_PER_MS;
   localparam int READY_CYCLES    =
      (lcd_cmd_pkg::RESET_LOW_MS + lcd_cmd_pkg::RESET_WAIT_MS) * CYCLES_PER_MS;
   // run length estimate: reset wait, init delays and bytes, two frames
   localparam int BYTE_CYCLES    = 16 * CLK_HALF_CYCLES + 6;
   localparam int INIT_MS        = 150 + 250 + 10 + 100;
   localparam int FRAME_CYCLES   = (11 + 2 * W * H) * BYTE_CYCLES + W * H * 10;
   localparam int RUN_CYCLES     = READY_CYCLES + INIT_MS * CYCLES_PER_MS
                                   + 23 * BYTE_CYCLES + 2 * FRAME_CYCLES;
   localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;

   logic clk;
   logic rst_n;
   logic [15:0] color;
   logic color_valid;
   logic lcd_sclk, lcd_mosi, lcd_dc, lcd_cs, lcd_rst;
   logic pixel_req;
   logic [$clog2(W)-1:0] pixel_x;
   logic [$clog2(H)-1:0] pixel_y;
   logic [7:0]  rx_byte;
   logic        rx_dc;
   logic [63:0] rx_start, rx_end;
   int          rx_count;

   // expected byte stream, gap is the ms delay before the byte
   logic [7:0] exp_byte[$];
   logic       exp_dc[$];
   int         exp_gap[$];
   string      exp_test[$];
   int         pending_gap = 0;
   int         byte_idx = 0;
   int         seen_count = 0;
   logic [63:0] prev_end = '0;
   int cycle = 0, since_rst = 0;
   int exp_x = 0, exp_y = 0, hold_x = 0, hold_y = 0;
   int wait_left = 0, req_count = 0;
   bit src_busy = 0;
   logic [31:0] rnd = 32'h72c1;

   st7735_top #(
      .CLK_HALF_CYCLES(CLK_HALF_CYCLES),
      .CYCLES_PER_MS(CYCLES_PER_MS),
      .SCREEN_WIDTH(W),
      .SCREEN_HEIGHT(H)
   ) st7735_top_i (
      .clk(clk), .rst_n(rst_n), .color(color), .color_valid(color_valid),
      .lcd_sclk(lcd_sclk), .lcd_mosi(lcd_mosi), .lcd_dc(lcd_dc), .lcd_cs(lcd_cs),
      .lcd_rst(lcd_rst), .pixel_req(pixel_req), .pixel_x(pixel_x), .pixel_y(pixel_y));

   spi_byte_decoder decoder_i (
      .sclk(lcd_sclk), .mosi(lcd_mosi), .dc(lcd_dc), .cs(lcd_cs),
      .rx_byte(rx_byte), .rx_dc(rx_dc), .rx_start(rx_start), .rx_end(rx_end),
      .rx_count(rx_count));

   function automatic logic [31:0] next_random(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic stop_on_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
      $display("FAILED %s expected %0h actual %0h", test, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic stop_on_error(input string what);
      $display("ERROR %s", what);
      $display("STATUS: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic add_byte(input string test, input logic [7:0] value, input logic is_data);
      exp_test.push_back(test);
      exp_byte.push_back(value);
      exp_dc.push_back(is_data);
      exp_gap.push_back(pending_gap);
      pending_gap = 0;
   endtask

   task automatic add_frame(input string win_test, input string pix_test);
      int col_end;
      int row_end;
      col_end = lcd_cmd_pkg::COL_OFFSET + W - 1;
      row_end = lcd_cmd_pkg::ROW_OFFSET + H - 1;
      add_byte(win_test, lcd_cmd_pkg::CASET, 1'b0);
      add_byte(win_test, 8'h00, 1'b1);
      add_byte(win_test, lcd_cmd_pkg::COL_OFFSET, 1'b1);
      add_byte(win_test, 8'(col_end >> 8), 1'b1);
      add_byte(win_test, 8'(col_end), 1'b1);
      add_byte(win_test, lcd_cmd_pkg::RASET, 1'b0);
      add_byte(win_test, 8'h00, 1'b1);
      add_byte(win_test, lcd_cmd_pkg::ROW_OFFSET, 1'b1);
      add_byte(win_test, 8'(row_end >> 8), 1'b1);
      add_byte(win_test, 8'(row_end), 1'b1);
      add_byte(win_test, lcd_cmd_pkg::RAMWR, 1'b0);
      for (int y = 0; y < H; y++) begin
         for (int x = 0; x < W; x++) begin
            add_byte(pix_test, 8'(x), 1'b1);           // colour high byte
            add_byte(pix_test, 8'(y * 16 + 5), 1'b1);
         end
      end
   endtask

   task automatic build_expected();
      add_byte("init", lcd_cmd_pkg::SWRESET, 1'b0);
      pending_gap = 150;
      add_byte("init", lcd_cmd_pkg::SLPOUT, 1'b0);
      pending_gap = 250;
      add_byte("init", lcd_cmd_pkg::INVCTR, 1'b0);
      add_byte("init", 8'h07, 1'b1);
      add_byte("init", lcd_cmd_pkg::PWCTR1, 1'b0);
      add_byte("init", 8'hA2, 1'b1);
      add_byte("init", 8'h02, 1'b1);
      add_byte("init", 8'h84, 1'b1);
      add_byte("init", lcd_cmd_pkg::PWCTR4, 1'b0);
      add_byte("init", 8'h8A, 1'b1);
      add_byte("init", 8'h2A, 1'b1);
      add_byte("init", lcd_cmd_pkg::PWCTR5, 1'b0);
      add_byte("init", 8'h8A, 1'b1);
      add_byte("init", 8'hEE, 1'b1);
      add_byte("init", lcd_cmd_pkg::VMCTR1, 1'b0);
      add_byte("init", 8'h0E, 1'b1);
      add_byte("init", lcd_cmd_pkg::INVON, 1'b0);
      add_byte("init", lcd_cmd_pkg::MADCTL, 1'b0);
      add_byte("init", 8'hC8, 1'b1);
      add_byte("init", lcd_cmd_pkg::COLMOD, 1'b0);
      add_byte("init", 8'h05, 1'b1);
      add_byte("init", lcd_cmd_pkg::NORON, 1'b0);
      pending_gap = 10;
      add_byte("init", lcd_cmd_pkg::DISPON, 1'b0);
      pending_gap = 100;                               // before the first CASET
      add_frame("window", "pixel");
      add_frame("repeat window", "repeat pixel");
   endtask

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // reset levels, panel reset pulse, quiet link before ready, timeout
   always @(posedge clk) begin
      cycle = cycle + 1;
      if (cycle >= TIMEOUT_CYCLES)
         stop_on_error("run did not finish within the cycle limit");
      if (!rst_n) begin
         if (cycle > 1)
            assert (lcd_rst === 1'b0 && lcd_cs === 1'b1 && lcd_sclk === 1'b1 &&
                    pixel_req === 1'b0)
               else stop_on_error("outputs not idle during reset");
      end else begin
         since_rst = since_rst + 1;
         if (since_rst <= RST_LOW_CYCLES - 2)
            assert (lcd_rst === 1'b0) else stop_on_mismatch("reset", 0, lcd_rst);
         if (since_rst >= RST_LOW_CYCLES + 2)
            assert (lcd_rst === 1'b1) else stop_on_mismatch("reset", 1, lcd_rst);
         if (since_rst < READY_CYCLES)
            assert (lcd_cs === 1'b1) else stop_on_error("byte started before the reset wait ended");
      end
   end

   // pixel source model with random back-pressure
   always @(posedge clk) begin
      if (!rst_n) begin
         color_valid <= 1'b0;
      end else if (color_valid) begin
         color_valid <= 1'b0;                          // one cycle only
      end else if (pixel_req) begin
         if (!src_busy) begin
            assert (pixel_x == exp_x) else stop_on_mismatch("pixel x", exp_x, pixel_x);
            assert (pixel_y == exp_y) else stop_on_mismatch("pixel y", exp_y, pixel_y);
            src_busy  = 1;
            hold_x    = pixel_x;
            hold_y    = pixel_y;
            rnd       = next_random(rnd);
            wait_left = rnd[2:0];
            req_count = req_count + 1;
         end else begin
            assert (pixel_x == hold_x && pixel_y == hold_y)
               else stop_on_mismatch("pixel hold", {hold_x[15:0], hold_y[15:0]},
                                     {16'(pixel_x), 16'(pixel_y)});
         end
         assert (lcd_cs === 1'b1) else stop_on_error("cs active while waiting for colour");
         if (wait_left == 0) begin
            color       <= 16'(hold_x * 256 + hold_y * 16 + 5);
            color_valid <= 1'b1;
            src_busy     = 0;
            exp_x        = exp_x + 1;
            if (exp_x == W) begin                      // raster order, x fastest
               exp_x = 0;
               exp_y = (exp_y == H - 1) ? 0 : exp_y + 1;
            end
         end else begin
            wait_left = wait_left - 1;
         end
      end
   end

   // decoded byte stream against the expected list
   always @(posedge clk) begin
      int gap;
      if (rx_count != seen_count) begin
         seen_count = rx_count;
         if (byte_idx >= exp_byte.size()) begin
            stop_on_error("more bytes on the link than expected");
         end else begin
            assert (rx_byte == exp_byte[byte_idx])
               else stop_on_mismatch(exp_test[byte_idx], exp_byte[byte_idx], rx_byte);
            assert (rx_dc == exp_dc[byte_idx])
               else stop_on_mismatch({exp_test[byte_idx], " dc"}, exp_dc[byte_idx], rx_dc);
            if (exp_gap[byte_idx] > 0) begin
               gap = (rx_start - prev_end) / CLK_PERIOD;
               assert (gap >= exp_gap[byte_idx] * CYCLES_PER_MS)
                  else stop_on_mismatch("delay", exp_gap[byte_idx] * CYCLES_PER_MS, gap);
            end
            prev_end = rx_end;
            byte_idx = byte_idx + 1;
         end
      end
   end

   initial begin
      rst_n       = 1'b0;
      color       = '0;
      color_valid = 1'b0;
      build_expected();
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      while (byte_idx < exp_byte.size())
         @(negedge clk);
      if (req_count != 2 * W * H) begin
         stop_on_mismatch("repeat requests", 2 * W * H, req_count);
      end else begin
         $display("STATUS: PASS");
         $finish;
      end
   end

endmodule

// File: project.f
hw/lcd_cmd_pkg.sv
hw/lcd_link_pkg.sv
hw/spi_byte_tx.sv
hw/panel_reset_gen.sv
hw/lcd_sequencer.sv
hw/frame_scanner.sv
hw/st7735_top.sv
tb/spi_byte_decoder.sv
tb/tb_st7735.sv
